//--- a2bus_pkg.sv
/*
 * Apple II bus definitions
 *   Data bus width and byte type
 *   Synchronizer depth and power-on reset hold length
 *   Output enables for the bus data and interrupt drivers
 */

package a2bus_pkg;

    // Data bus
    localparam int A2_DATA_W = 8;

    typedef logic [A2_DATA_W-1:0] a2_data_t;

    // Flops in the phi1 synchronizer chain
    localparam int SYNC_STAGES = 2;

    // Logic cycles the device reset is held after reset_i drops
    localparam int RESET_HOLD_CYCLES = 64;
    localparam int RESET_HOLD_W = $clog2(RESET_HOLD_CYCLES);

    // Bus output enables
    // Clearing either one keeps that driver released on the bus
    localparam bit IRQ_OUT_ENABLE = 1'b1;
    localparam bit BUS_DATA_OUT_ENABLE = 1'b1;

endpackage

//--- esp32_stream_pkg.sv
/*
 * Audio and ESP32 stream definitions
 *   Card audio and mixed sample types, mix widths
 *   Stream word and nibble types, send period, marker word
 *   Nibble timing and derived counter widths
 */

package esp32_stream_pkg;

    // Audio
    localparam int CARD_AUDIO_W = 10;
    localparam int MIX_W = 13;
    localparam int SAMPLE_W = 16;

    typedef logic [CARD_AUDIO_W-1:0] card_audio_t;
    typedef logic signed [SAMPLE_W-1:0] mix_sample_t;

    // Parallel stream
    localparam int PARL_WORD_W = 32;
    localparam int PARL_NIBBLE_W = 4;

    typedef logic [PARL_WORD_W-1:0] parl_word_t;
    typedef logic [PARL_NIBBLE_W-1:0] parl_nibble_t;

    localparam int SEND_PERIOD = 256;
    localparam int SEND_CNT_W = $clog2(SEND_PERIOD);
    localparam parl_word_t STREAM_MARKER = 32'h1234_5678;

    localparam int NIBBLE_CYCLES = 2;
    localparam int NIBBLE_PHASE_W = $clog2(NIBBLE_CYCLES);
    localparam int NIBBLES_PER_WORD = PARL_WORD_W / PARL_NIBBLE_W;
    localparam int NIBBLE_CNT_W = $clog2(NIBBLES_PER_WORD);

endpackage

//--- a2_timing_if.sv
/*
 * Bus timing interface
 *   Synchronized phi0 and phi1 phases with one-cycle edge pulses
 *   Device reset and system reset, both active low
 */

`timescale 1ns/1ps

interface a2_timing_if;

    logic phi0;
    logic phi1;
    logic phi1_posedge;
    logic phi1_negedge;
    logic device_reset_n;
    logic system_reset_n;

    // Driven by the bus clock block
    modport source (
        output phi0,
        output phi1,
        output phi1_posedge,
        output phi1_negedge,
        output device_reset_n,
        output system_reset_n
    );

    modport sink (
        input phi0,
        input phi1,
        input phi1_posedge,
        input phi1_negedge,
        input device_reset_n,
        input system_reset_n
    );

endinterface

//--- bus_clocking.sv
/*
 * Bus clock and reset generation
 *   phi1 synchronizer with a two-sample agreement filter
 *   phi0 and phi1 phases with one-cycle edge pulses
 *   Power-on reset hold counter and registered bus reset
 */

`timescale 1ns/1ps

module bus_clocking (
    input  logic        clk_logic_w,
    input  logic        reset_i,
    input  logic        a2_phi1_i,
    input  logic        a2_reset_n_i,
    a2_timing_if.source timing
);

    logic [a2bus_pkg::SYNC_STAGES-1:0] phi1_sync_r;
    logic                              phi1_sample_w;
    logic                              phi1_agree_w;
    logic                              phi1_r;
    logic                              phi1_posedge_r;
    logic                              phi1_negedge_r;
    logic [a2bus_pkg::RESET_HOLD_W-1:0] hold_cnt_r;
    logic                              device_reset_n_r;
    logic                              a2_reset_n_r;

    // Synchronizer chain, oldest sample at the top
    always_ff @(posedge clk_logic_w) begin
        phi1_sync_r <= {phi1_sync_r[a2bus_pkg::SYNC_STAGES-2:0], a2_phi1_i};
    end

    assign phi1_sample_w = phi1_sync_r[a2bus_pkg::SYNC_STAGES-1];
    assign phi1_agree_w  = (phi1_sync_r[a2bus_pkg::SYNC_STAGES-1] ==
                            phi1_sync_r[a2bus_pkg::SYNC_STAGES-2]);

    // Only follow the input once two samples agree, so single-cycle glitches are dropped
    always_ff @(posedge clk_logic_w) begin
        if (reset_i) begin
            phi1_r         <= 1'b0;
            phi1_posedge_r <= 1'b0;
            phi1_negedge_r <= 1'b0;
        end else begin
            phi1_posedge_r <= 1'b0;
            phi1_negedge_r <= 1'b0;
            if (phi1_agree_w && (phi1_sample_w != phi1_r)) begin
                phi1_r         <= phi1_sample_w;
                phi1_posedge_r <= phi1_sample_w;
                phi1_negedge_r <= ~phi1_sample_w;
            end
        end
    end

    // Device reset released after the hold count expires
    always_ff @(posedge clk_logic_w) begin
        if (reset_i) begin
            hold_cnt_r       <= '0;
            device_reset_n_r <= 1'b0;
            a2_reset_n_r     <= 1'b0;
        end else begin
            a2_reset_n_r <= a2_reset_n_i;
            if (!device_reset_n_r) begin
                hold_cnt_r <= hold_cnt_r + 1'b1;
                if (hold_cnt_r == a2bus_pkg::RESET_HOLD_CYCLES - 1) begin
                    device_reset_n_r <= 1'b1;
                end
            end
        end
    end

    assign timing.phi1           = phi1_r;
    assign timing.phi0           = ~phi1_r;
    assign timing.phi1_posedge   = phi1_posedge_r;
    assign timing.phi1_negedge   = phi1_negedge_r;
    assign timing.device_reset_n = device_reset_n_r;
    assign timing.system_reset_n = device_reset_n_r & a2_reset_n_r;

endmodule

//--- card_bus_driver.sv
/*
 * Card data bus and interrupt driver
 *   Captures the bus byte at the end of phi0
 *   Selects read data by fixed priority: serial, sprite, sound card
 *   Combines the card interrupt lines onto the bus interrupt
 */

`timescale 1ns/1ps

module card_bus_driver (
    input  logic                clk_logic_w,
    a2_timing_if.sink           timing,
    input  a2bus_pkg::a2_data_t a2_d_i,
    input  logic                ssc_rd_i,
    input  logic                ssp_rd_i,
    input  logic                mb_rd_i,
    input  a2bus_pkg::a2_data_t ssc_data_i,
    input  a2bus_pkg::a2_data_t ssp_data_i,
    input  a2bus_pkg::a2_data_t mb_data_i,
    input  logic                ssc_irq_n_i,
    input  logic                ssp_irq_n_i,
    input  logic                mb_irq_n_i,
    output a2bus_pkg::a2_data_t a2_d_o,
    output logic                a2_d_dir_o,
    output logic                a2_irq_n_o
);

    a2bus_pkg::a2_data_t data_capture_r;
    a2bus_pkg::a2_data_t data_out_w;
    logic                read_any_w;
    logic                irq_n_w;

    // Bus byte is stable at the end of phi0
    always_ff @(posedge clk_logic_w) begin
        if (timing.phi1_posedge) begin
            data_capture_r <= a2_d_i;
        end
    end

    // Serial card wins, then sprite, then sound card
    always_comb begin
        if (ssc_rd_i) begin
            data_out_w = ssc_data_i;
        end else if (ssp_rd_i) begin
            data_out_w = ssp_data_i;
        end else if (mb_rd_i) begin
            data_out_w = mb_data_i;
        end else begin
            data_out_w = data_capture_r;
        end
    end

    assign read_any_w = ssc_rd_i | ssp_rd_i | mb_rd_i;

    // Wired-AND of the open-drain card lines
    assign irq_n_w = ssc_irq_n_i & ssp_irq_n_i & mb_irq_n_i;

    always_ff @(posedge clk_logic_w) begin
        if (!timing.system_reset_n) begin
            a2_d_o     <= '0;
            a2_d_dir_o <= 1'b0;
            a2_irq_n_o <= 1'b1;
        end else begin
            a2_d_o     <= data_out_w;
            a2_d_dir_o <= read_any_w & a2bus_pkg::BUS_DATA_OUT_ENABLE;
            a2_irq_n_o <= irq_n_w | ~a2bus_pkg::IRQ_OUT_ENABLE;
        end
    end

endmodule

//--- audio_mixer.sv
/*
 * Stereo audio mixer
 *   Widens speaker, sprite and sound card audio to the mix width
 *   Sums them into registered left and right samples
 */

`timescale 1ns/1ps

module audio_mixer (
    input  logic                          clk_logic_w,
    a2_timing_if.sink                     timing,
    input  logic                          speaker_i,
    input  esp32_stream_pkg::card_audio_t ssp_audio_i,
    input  esp32_stream_pkg::card_audio_t mb_audio_l_i,
    input  esp32_stream_pkg::card_audio_t mb_audio_r_i,
    output esp32_stream_pkg::mix_sample_t audio_l_o,
    output esp32_stream_pkg::mix_sample_t audio_r_o
);

    localparam int PAD_W = esp32_stream_pkg::SAMPLE_W - esp32_stream_pkg::MIX_W;
    localparam int SHIFT_W = esp32_stream_pkg::MIX_W - esp32_stream_pkg::CARD_AUDIO_W;

    logic [esp32_stream_pkg::MIX_W-1:0] speaker_ext_w;
    logic [esp32_stream_pkg::MIX_W-1:0] ssp_ext_w;
    logic [esp32_stream_pkg::MIX_W-1:0] mb_l_ext_w;
    logic [esp32_stream_pkg::MIX_W-1:0] mb_r_ext_w;
    esp32_stream_pkg::mix_sample_t      sum_l_w;
    esp32_stream_pkg::mix_sample_t      sum_r_w;

    // Speaker is a single bit, so it lands on the top bit of the mix width
    assign speaker_ext_w = {speaker_i, {(esp32_stream_pkg::MIX_W - 1){1'b0}}};
    assign ssp_ext_w     = {ssp_audio_i, {SHIFT_W{1'b0}}};
    assign mb_l_ext_w    = {mb_audio_l_i, {SHIFT_W{1'b0}}};
    assign mb_r_ext_w    = {mb_audio_r_i, {SHIFT_W{1'b0}}};

    assign sum_l_w = {{PAD_W{1'b0}}, speaker_ext_w} + {{PAD_W{1'b0}}, ssp_ext_w} +
                     {{PAD_W{1'b0}}, mb_l_ext_w};
    assign sum_r_w = {{PAD_W{1'b0}}, speaker_ext_w} + {{PAD_W{1'b0}}, ssp_ext_w} +
                     {{PAD_W{1'b0}}, mb_r_ext_w};

    always_ff @(posedge clk_logic_w) begin
        if (!timing.device_reset_n) begin
            audio_l_o <= '0;
            audio_r_o <= '0;
        end else begin
            audio_l_o <= sum_l_w;
            audio_r_o <= sum_r_w;
        end
    end

endmodule

//--- parl_serializer.sv
/*
 * ESP32 parallel stream serializer
 *   Periodic send strobe and marker/sample word alternation
 *   32-bit shift register sent as nibbles, most significant first
 *   Active-low frame and nibble clock generation
 */

`timescale 1ns/1ps

module parl_serializer (
    input  logic                           clk_logic_w,
    a2_timing_if.sink                      timing,
    input  esp32_stream_pkg::mix_sample_t  audio_l_i,
    input  esp32_stream_pkg::mix_sample_t  audio_r_i,
    output logic                           esp32_parl_clk_o,
    output logic                           esp32_parl_frame_o,
    output esp32_stream_pkg::parl_nibble_t esp32_parl_d_o
);

    logic [esp32_stream_pkg::SEND_CNT_W-1:0]     send_cnt_r;
    logic                                        send_strobe_w;
    logic                                        send_switch_r;
    esp32_stream_pkg::parl_word_t                send_word_w;
    esp32_stream_pkg::parl_word_t                shift_r;
    logic [esp32_stream_pkg::NIBBLE_CNT_W-1:0]   nib_cnt_r;
    logic [esp32_stream_pkg::NIBBLE_PHASE_W-1:0] phase_r;
    logic                                        nibble_done_w;

    assign send_strobe_w = (send_cnt_r == '0);

    // Marker first, then the stereo sample with right in the upper half
    assign send_word_w = send_switch_r ? {audio_r_i, audio_l_i} :
                                         esp32_stream_pkg::STREAM_MARKER;

    assign nibble_done_w = !esp32_parl_frame_o &&
                           (phase_r == esp32_stream_pkg::NIBBLE_CYCLES - 1);

    always_ff @(posedge clk_logic_w) begin
        if (!timing.system_reset_n) begin
            send_cnt_r         <= '0;
            send_switch_r      <= 1'b0;
            esp32_parl_frame_o <= 1'b1;
            esp32_parl_clk_o   <= 1'b0;
            nib_cnt_r          <= '0;
            phase_r            <= '0;
        end else begin
            if (send_cnt_r == esp32_stream_pkg::SEND_PERIOD - 1) begin
                send_cnt_r <= '0;
            end else begin
                send_cnt_r <= send_cnt_r + 1'b1;
            end

            if (send_strobe_w) begin
                send_switch_r      <= ~send_switch_r;
                esp32_parl_frame_o <= 1'b0;
                esp32_parl_clk_o   <= 1'b0;
                nib_cnt_r          <= '0;
                phase_r            <= '0;
            end else if (nibble_done_w) begin
                esp32_parl_clk_o <= 1'b0;
                phase_r          <= '0;
                nib_cnt_r        <= nib_cnt_r + 1'b1;
                if (nib_cnt_r == esp32_stream_pkg::NIBBLES_PER_WORD - 1) begin
                    esp32_parl_frame_o <= 1'b1;
                end
            end else if (!esp32_parl_frame_o) begin
                // Clock goes high for the second half of each nibble
                phase_r          <= phase_r + 1'b1;
                esp32_parl_clk_o <= (int'(phase_r) + 1 >= esp32_stream_pkg::NIBBLE_CYCLES / 2);
            end
        end
    end

    always_ff @(posedge clk_logic_w) begin
        if (send_strobe_w) begin
            shift_r <= send_word_w;
        end else if (nibble_done_w) begin
            shift_r <= shift_r << esp32_stream_pkg::PARL_NIBBLE_W;
        end
    end

    assign esp32_parl_d_o = shift_r[esp32_stream_pkg::PARL_WORD_W-1 -:
                                    esp32_stream_pkg::PARL_NIBBLE_W];

endmodule

//--- a2card_top.sv
/*
 * Apple II card glue top level
 *   Bus clock sync and reset generation
 *   Data bus read-back and interrupt combine
 *   Audio mixer and ESP32 parallel stream
 */

`timescale 1ns/1ps

module a2card_top (
    input  logic                                      clk_logic_w,
    input  logic                                      reset_i,
    input  logic                                      a2_phi1_i,
    input  logic                                      a2_reset_n_i,
    input  logic [a2bus_pkg::A2_DATA_W-1:0]           a2_d_i,
    input  logic                                      ssc_rd_i,
    input  logic                                      ssp_rd_i,
    input  logic                                      mb_rd_i,
    input  logic [a2bus_pkg::A2_DATA_W-1:0]           ssc_data_i,
    input  logic [a2bus_pkg::A2_DATA_W-1:0]           ssp_data_i,
    input  logic [a2bus_pkg::A2_DATA_W-1:0]           mb_data_i,
    input  logic                                      ssc_irq_n_i,
    input  logic                                      ssp_irq_n_i,
    input  logic                                      mb_irq_n_i,
    input  logic                                      speaker_i,
    input  logic [esp32_stream_pkg::CARD_AUDIO_W-1:0] ssp_audio_i,
    input  logic [esp32_stream_pkg::CARD_AUDIO_W-1:0] mb_audio_l_i,
    input  logic [esp32_stream_pkg::CARD_AUDIO_W-1:0] mb_audio_r_i,
    output logic [a2bus_pkg::A2_DATA_W-1:0]           a2_d_o,
    output logic                                      a2_d_dir_o,
    output logic                                      a2_irq_n_o,
    output logic [esp32_stream_pkg::SAMPLE_W-1:0]     audio_l_o,
    output logic [esp32_stream_pkg::SAMPLE_W-1:0]     audio_r_o,
    output logic                                      esp32_parl_clk_o,
    output logic                                      esp32_parl_frame_o,
    output logic [esp32_stream_pkg::PARL_NIBBLE_W-1:0] esp32_parl_d_o
);

    // Mixed samples go to the outputs and the stream serializer
    esp32_stream_pkg::mix_sample_t audio_l_w;
    esp32_stream_pkg::mix_sample_t audio_r_w;

    a2_timing_if u_timing ();

    bus_clocking u_bus_clocking (
        .clk_logic_w  (clk_logic_w),
        .reset_i      (reset_i),
        .a2_phi1_i    (a2_phi1_i),
        .a2_reset_n_i (a2_reset_n_i),
        .timing       (u_timing.source)
    );

    card_bus_driver u_card_bus_driver (
        .clk_logic_w (clk_logic_w),
        .timing      (u_timing.sink),
        .a2_d_i      (a2_d_i),
        .ssc_rd_i    (ssc_rd_i),
        .ssp_rd_i    (ssp_rd_i),
        .mb_rd_i     (mb_rd_i),
        .ssc_data_i  (ssc_data_i),
        .ssp_data_i  (ssp_data_i),
        .mb_data_i   (mb_data_i),
        .ssc_irq_n_i (ssc_irq_n_i),
        .ssp_irq_n_i (ssp_irq_n_i),
        .mb_irq_n_i  (mb_irq_n_i),
        .a2_d_o      (a2_d_o),
        .a2_d_dir_o  (a2_d_dir_o),
        .a2_irq_n_o  (a2_irq_n_o)
    );

    audio_mixer u_audio_mixer (
        .clk_logic_w  (clk_logic_w),
        .timing       (u_timing.sink),
        .speaker_i    (speaker_i),
        .ssp_audio_i  (ssp_audio_i),
        .mb_audio_l_i (mb_audio_l_i),
        .mb_audio_r_i (mb_audio_r_i),
        .audio_l_o    (audio_l_w),
        .audio_r_o    (audio_r_w)
    );

    parl_serializer u_parl_serializer (
        .clk_logic_w        (clk_logic_w),
        .timing             (u_timing.sink),
        .audio_l_i          (audio_l_w),
        .audio_r_i          (audio_r_w),
        .esp32_parl_clk_o   (esp32_parl_clk_o),
        .esp32_parl_frame_o (esp32_parl_frame_o),
        .esp32_parl_d_o     (esp32_parl_d_o)
    );

    assign audio_l_o = audio_l_w;
    assign audio_r_o = audio_r_w;

endmodule

//--- a2card_properties.sv
/*
 * Concurrent checks on the card top level
 *   ESP32 frame length
 *   Interrupt release and data bus direction release
 */

`timescale 1ns/1ps

module a2card_properties (
    input logic clk_logic_w,
    input logic reset_i,
    input logic ssc_rd_i,
    input logic ssp_rd_i,
    input logic mb_rd_i,
    input logic ssc_irq_n_i,
    input logic ssp_irq_n_i,
    input logic mb_irq_n_i,
    input logic d_dir_i,
    input logic irq_n_i,
    input logic parl_frame_i
);

    localparam int FRAME_CYCLES =
        esp32_stream_pkg::NIBBLES_PER_WORD * esp32_stream_pkg::NIBBLE_CYCLES;

    // Number of assertion failures so far
    int assert_fail_count = 0;

    // One frame is 8 nibbles of two cycles each
    frame_length_a: assert property (@(posedge clk_logic_w) disable iff (reset_i)
        $fell(parl_frame_i) |-> ##[1:FRAME_CYCLES] parl_frame_i)
        else begin
            assert_fail_count++;
            $error("ESP32 frame stayed low longer than one word");
        end

    irq_release_a: assert property (@(posedge clk_logic_w) disable iff (reset_i)
        (ssc_irq_n_i && ssp_irq_n_i && mb_irq_n_i) |=> irq_n_i)
        else begin
            assert_fail_count++;
            $error("Bus interrupt held low with all card lines released");
        end

    dir_release_a: assert property (@(posedge clk_logic_w) disable iff (reset_i)
        !(ssc_rd_i || ssp_rd_i || mb_rd_i) |=> !d_dir_i)
        else begin
            assert_fail_count++;
            $error("Data bus driven with no read active");
        end

endmodule

bind a2card_top a2card_properties u_properties (
    .clk_logic_w  (clk_logic_w),
    .reset_i      (reset_i),
    .ssc_rd_i     (ssc_rd_i),
    .ssp_rd_i     (ssp_rd_i),
    .mb_rd_i      (mb_rd_i),
    .ssc_irq_n_i  (ssc_irq_n_i),
    .ssp_irq_n_i  (ssp_irq_n_i),
    .mb_irq_n_i   (mb_irq_n_i),
    .d_dir_i      (a2_d_dir_o),
    .irq_n_i      (a2_irq_n_o),
    .parl_frame_i (esp32_parl_frame_o)
);

//--- tb_a2card.sv
/*
 * Directed testbench for the Apple II card glue
 *   Clock, reset and bus input drivers
 *   Typed compare tasks and one task per checked behavior
 */

`timescale 1ns/1ps

module tb_a2card;

    localparam time CLK_PERIOD     = 20ns;
    localparam int  RESET_CYCLES   = 5;
    localparam int  FRAME_TIMEOUT  = esp32_stream_pkg::SEND_PERIOD + 32;
    localparam int  NIBBLE_TIMEOUT = 40;

    logic                          clk_logic_w;
    logic                          reset_i;
    logic                          a2_phi1_i;
    logic                          a2_reset_n_i;
    a2bus_pkg::a2_data_t           a2_d_i;
    logic                          ssc_rd_i;
    logic                          ssp_rd_i;
    logic                          mb_rd_i;
    a2bus_pkg::a2_data_t           ssc_data_i;
    a2bus_pkg::a2_data_t           ssp_data_i;
    a2bus_pkg::a2_data_t           mb_data_i;
    logic                          ssc_irq_n_i;
    logic                          ssp_irq_n_i;
    logic                          mb_irq_n_i;
    logic                          speaker_i;
    esp32_stream_pkg::card_audio_t ssp_audio_i;
    esp32_stream_pkg::card_audio_t mb_audio_l_i;
    esp32_stream_pkg::card_audio_t mb_audio_r_i;
    a2bus_pkg::a2_data_t           a2_d_o;
    logic                          a2_d_dir_o;
    logic                          a2_irq_n_o;
    esp32_stream_pkg::mix_sample_t audio_l_o;
    esp32_stream_pkg::mix_sample_t audio_r_o;
    logic                          esp32_parl_clk_o;
    logic                          esp32_parl_frame_o;
    esp32_stream_pkg::parl_nibble_t esp32_parl_d_o;

    integer                        seed;
    int                            check_count;
    int                            error_count;
    int                            timeout_count;
    a2bus_pkg::a2_data_t           captured_byte;
    esp32_stream_pkg::mix_sample_t exp_l;
    esp32_stream_pkg::mix_sample_t exp_r;

    a2card_top u_dut (.*);

    initial begin
        clk_logic_w = 1'b0;
        forever #(CLK_PERIOD / 2) clk_logic_w = ~clk_logic_w;
    end

    function automatic logic [31:0] random_word();
        logic [31:0] value;
        value = $random(seed);
        return value;
    endfunction

    task automatic check_data(input string name, input a2bus_pkg::a2_data_t expected,
                              input a2bus_pkg::a2_data_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL %0t %s expected %b actual %b", $time, name, expected, actual);
        end
    endtask

    task automatic check_sample(input string name, input esp32_stream_pkg::mix_sample_t expected,
                                input esp32_stream_pkg::mix_sample_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_word(input string name, input esp32_stream_pkg::parl_word_t expected,
                              input esp32_stream_pkg::parl_word_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_reset_outputs();
        check_data("a2_d_o", '0, a2_d_o);
        check_bit("a2_d_dir_o", 1'b0, a2_d_dir_o);
        check_bit("a2_irq_n_o", 1'b1, a2_irq_n_o);
        check_bit("esp32_parl_frame_o", 1'b1, esp32_parl_frame_o);
        check_bit("esp32_parl_clk_o", 1'b0, esp32_parl_clk_o);
        check_sample("audio_l_o", '0, audio_l_o);
        check_sample("audio_r_o", '0, audio_r_o);
    endtask

    task automatic wait_reset_hold();
        for (int i = 0; i < a2bus_pkg::RESET_HOLD_CYCLES + 4; i++) begin
            @(negedge clk_logic_w);
        end
    endtask

    task automatic test_capture();
        captured_byte = a2bus_pkg::a2_data_t'(random_word());
        a2_d_i        = captured_byte;
        a2_phi1_i     = 1'b1;
        // Three edges through the sync, one to capture, one to the output register
        repeat (6) @(negedge clk_logic_w);
        check_data("a2_d_o", captured_byte, a2_d_o);
        check_bit("a2_d_dir_o", 1'b0, a2_d_dir_o);
        // No further phi1 edge follows, so this byte must not be captured
        a2_d_i = ~captured_byte;
    endtask

    task automatic test_read_priority();
        a2bus_pkg::a2_data_t base;
        a2bus_pkg::a2_data_t expected;
        logic [2:0]          rd;
        for (int combo = 0; combo < 8; combo++) begin
            base       = a2bus_pkg::a2_data_t'(random_word());
            rd         = 3'(combo);
            ssc_data_i = base;
            ssp_data_i = base ^ 8'h5a;
            mb_data_i  = base ^ 8'ha5;
            ssc_rd_i   = rd[2];
            ssp_rd_i   = rd[1];
            mb_rd_i    = rd[0];
            if (rd[2]) begin
                expected = ssc_data_i;
            end else if (rd[1]) begin
                expected = ssp_data_i;
            end else if (rd[0]) begin
                expected = mb_data_i;
            end else begin
                expected = captured_byte;
            end
            @(negedge clk_logic_w);
            check_data("a2_d_o", expected, a2_d_o);
            check_bit("a2_d_dir_o", |rd, a2_d_dir_o);
        end
        ssc_rd_i = 1'b0;
        ssp_rd_i = 1'b0;
        mb_rd_i  = 1'b0;
    endtask

    task automatic test_irq_combine();
        logic [2:0] lines;
        for (int combo = 0; combo < 8; combo++) begin
            lines       = 3'(combo);
            ssc_irq_n_i = lines[2];
            ssp_irq_n_i = lines[1];
            mb_irq_n_i  = lines[0];
            @(negedge clk_logic_w);
            check_bit("a2_irq_n_o", &lines, a2_irq_n_o);
        end
    endtask

    task automatic test_audio_mix();
        logic [31:0] r;
        int          shift;
        int          common;
        r            = random_word();
        shift        = esp32_stream_pkg::MIX_W - esp32_stream_pkg::CARD_AUDIO_W;
        speaker_i    = 1'b1;
        ssp_audio_i  = r[9:0];
        mb_audio_l_i = r[19:10];
        mb_audio_r_i = r[29:20];
        // Speaker sits on the top mix bit, card audio moves up by three
        common = (1 << (esp32_stream_pkg::MIX_W - 1)) + (int'(ssp_audio_i) << shift);
        exp_l  = esp32_stream_pkg::mix_sample_t'(common + (int'(mb_audio_l_i) << shift));
        exp_r  = esp32_stream_pkg::mix_sample_t'(common + (int'(mb_audio_r_i) << shift));
        @(negedge clk_logic_w);
        check_sample("audio_l_o", exp_l, audio_l_o);
        check_sample("audio_r_o", exp_r, audio_r_o);
    endtask

    task automatic collect_frame(output esp32_stream_pkg::parl_word_t word);
        int   wait_cycles;
        int   nibbles;
        logic prev_clk;
        word        = '0;
        wait_cycles = 0;
        while (esp32_parl_frame_o !== 1'b0 && wait_cycles < FRAME_TIMEOUT) begin
            @(negedge clk_logic_w);
            wait_cycles++;
        end
        if (esp32_parl_frame_o !== 1'b0) begin
            timeout_count++;
            $display("Timeout: the ESP32 stream frame never went low");
        end else begin
            nibbles     = 0;
            wait_cycles = 0;
            prev_clk    = esp32_parl_clk_o;
            while (nibbles < esp32_stream_pkg::NIBBLES_PER_WORD &&
                   wait_cycles < NIBBLE_TIMEOUT) begin
                @(negedge clk_logic_w);
                wait_cycles++;
                // Each nibble is taken on a rising edge of the nibble clock
                if (esp32_parl_frame_o === 1'b0 && prev_clk === 1'b0 &&
                    esp32_parl_clk_o === 1'b1) begin
                    word = {word[27:0], esp32_parl_d_o};
                    nibbles++;
                end
                prev_clk = esp32_parl_clk_o;
            end
            if (nibbles < esp32_stream_pkg::NIBBLES_PER_WORD) begin
                timeout_count++;
                $display("Timeout: the ESP32 stream frame ended before 8 nibbles arrived");
            end else begin
                // Frame rises right after the second half of the last nibble
                @(negedge clk_logic_w);
                check_bit("esp32_parl_frame_o", 1'b1, esp32_parl_frame_o);
            end
        end
    endtask

    task automatic test_stream();
        esp32_stream_pkg::parl_word_t word;
        // A bus reset pulse restarts the send counter, so the marker goes first
        a2_reset_n_i = 1'b0;
        repeat (2) @(negedge clk_logic_w);
        a2_reset_n_i = 1'b1;
        collect_frame(word);
        check_word("stream marker word", esp32_stream_pkg::STREAM_MARKER, word);
        collect_frame(word);
        check_word("stream sample word", {exp_r, exp_l}, word);
    endtask

    initial begin
        seed          = 32'h5f063f8f;
        check_count   = 0;
        error_count   = 0;
        timeout_count = 0;
        reset_i       = 1'b1;
        a2_phi1_i     = 1'b0;
        a2_reset_n_i  = 1'b1;
        a2_d_i        = '0;
        ssc_rd_i      = 1'b0;
        ssp_rd_i      = 1'b0;
        mb_rd_i       = 1'b0;
        ssc_data_i    = '0;
        ssp_data_i    = '0;
        mb_data_i     = '0;
        ssc_irq_n_i   = 1'b1;
        ssp_irq_n_i   = 1'b1;
        mb_irq_n_i    = 1'b1;
        speaker_i     = 1'b0;
        ssp_audio_i   = '0;
        mb_audio_l_i  = '0;
        mb_audio_r_i  = '0;

        repeat (RESET_CYCLES) @(negedge clk_logic_w);
        check_reset_outputs();
        reset_i = 1'b0;
        @(negedge clk_logic_w);
        check_reset_outputs();
        wait_reset_hold();

        test_capture();
        test_read_priority();
        test_irq_combine();
        test_audio_mix();
        test_stream();

        $display("Checks: %0d, mismatches: %0d, timeouts: %0d, assertion failures: %0d",
                 check_count, error_count, timeout_count,
                 u_dut.u_properties.assert_fail_count);
        if (error_count == 0 && timeout_count == 0 &&
            u_dut.u_properties.assert_fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- a2card.f
a2bus_pkg.sv
esp32_stream_pkg.sv
a2_timing_if.sv
bus_clocking.sv
card_bus_driver.sv
audio_mixer.sv
parl_serializer.sv
a2card_top.sv
a2card_properties.sv
tb_a2card.sv

//--- Bender.yml
package:
  name: a2card

sources:
  # Design sources in compile order
  - files:
      - a2bus_pkg.sv
      - esp32_stream_pkg.sv
      - a2_timing_if.sv
      - bus_clocking.sv
      - card_bus_driver.sv
      - audio_mixer.sv
      - parl_serializer.sv
      - a2card_top.sv

  # Verification sources
  - target: test
    files:
      - a2card_properties.sv
      - tb_a2card.sv
